// File: hw/cdb_pkg.sv
package cdb_pkg;

  // units sharing the result bus
  localparam int NUM_FU   = 2;
  localparam int FU_ALU   = 0;
  localparam int FU_MULT  = 1;

  // core sizing
  localparam int NUM_PREG = 64;
  localparam int NUM_ROB  = 32;
  localparam int XLEN     = 32;

  typedef logic [$clog2(NUM_PREG)-1:0] preg_tag_t;
  typedef logic [$clog2(NUM_ROB)-1:0]  rob_idx_t;
  typedef logic [XLEN-1:0]             word_t;

  typedef enum logic [1:0] {
    ALU_ADD = 2'd0,
    ALU_SUB = 2'd1,
    ALU_AND = 2'd2,
    ALU_XOR = 2'd3
  } alu_op_t;

  // one issued op, valid is a one-cycle strobe
  typedef struct packed {
    logic      valid;
    alu_op_t   op;
    word_t     src_a;
    word_t     src_b;
    preg_tag_t tag;
    rob_idx_t  rob_idx;
  } issue_op_t;

  // finished result offered by a unit
  typedef struct packed {
    logic      valid;
    preg_tag_t tag;
    word_t     value;
    rob_idx_t  rob_idx;
  } fu_result_t;

  // bus broadcast, same layout as a unit result
  typedef fu_result_t cdb_bcast_t;

  typedef struct packed {
    logic     valid;
    rob_idx_t rollback_idx;
    rob_idx_t tail_idx;
  } rollback_t;

  // younger than rollback point, up to tail, modulo rob size
  // the rollback instruction itself survives
  function automatic logic is_squashed(rob_idx_t idx, rollback_t rb);
    rob_idx_t dist_entry;
    rob_idx_t dist_tail;
    dist_entry = idx - rb.rollback_idx;
    dist_tail  = rb.tail_idx - rb.rollback_idx;
    return rb.valid && (dist_entry != '0) && (dist_entry <= dist_tail);
  endfunction

endpackage

// File: hw/alu_unit.sv
`timescale 1ns/1ps

module alu_unit import cdb_pkg::*; (
  input  logic       clock,
  input  logic       reset,
  input  issue_op_t  issue,
  input  rollback_t  rollback,
  input  logic       entry_free,
  output fu_result_t result,
  output logic       issue_ready
);

  logic      res_valid;
  preg_tag_t res_tag;
  word_t     res_value;
  rob_idx_t  res_rob;
  word_t     alu_out;
  logic      issue_fire;

  always_comb begin
    case (issue.op)
      ALU_ADD: alu_out = issue.src_a + issue.src_b;
      ALU_SUB: alu_out = issue.src_a - issue.src_b;
      ALU_AND: alu_out = issue.src_a & issue.src_b;
      default: alu_out = issue.src_a ^ issue.src_b;
    endcase
  end

  // register empty or being handed to the arbiter this cycle
  assign issue_ready = !res_valid || entry_free;
  assign issue_fire  = issue.valid && issue_ready;

  always_ff @(posedge clock) begin
    if (reset) begin
      res_valid <= 1'b0;
    end else if (issue_fire) begin
      // an op issued in a rollback cycle may already be dead
      res_valid <= !is_squashed(issue.rob_idx, rollback);
    end else if (entry_free || is_squashed(res_rob, rollback)) begin
      res_valid <= 1'b0;
    end
  end

  // payload only moves on issue
  always_ff @(posedge clock) begin
    if (issue_fire) begin
      res_tag   <= issue.tag;
      res_value <= alu_out;
      res_rob   <= issue.rob_idx;
    end
  end

  assign result = '{valid: res_valid, tag: res_tag, value: res_value, rob_idx: res_rob};

endmodule

// File: hw/mult_unit.sv
`timescale 1ns/1ps

module mult_unit import cdb_pkg::*; #(
  parameter int MULT_STAGES = 3
) (
  input  logic       clock,
  input  logic       reset,
  input  issue_op_t  issue,
  input  rollback_t  rollback,
  input  logic       entry_free,
  output fu_result_t result,
  output logic       issue_ready
);

  localparam int LAST = MULT_STAGES - 1;

  logic [MULT_STAGES-1:0] stg_valid;
  logic [MULT_STAGES-1:0] hold;
  preg_tag_t              stg_tag  [MULT_STAGES];
  rob_idx_t               stg_rob  [MULT_STAGES];
  word_t                  stg_prod [MULT_STAGES];

  // stage i holds when it and every later stage is full and the last one is stuck
  always_comb begin
    for (int i = 0; i < MULT_STAGES; i++) begin
      hold[i] = !entry_free;
      for (int k = i; k < MULT_STAGES; k++) begin
        hold[i] = hold[i] && stg_valid[k];
      end
    end
  end

  // low only when the pipe is full and stalled
  assign issue_ready = !hold[0];

  always_ff @(posedge clock) begin
    if (reset) begin
      stg_valid <= '0;
    end else begin
      if (hold[0]) stg_valid[0] <= !is_squashed(stg_rob[0], rollback);
      else         stg_valid[0] <= issue.valid && !is_squashed(issue.rob_idx, rollback);
      for (int j = 1; j < MULT_STAGES; j++) begin
        if (hold[j]) stg_valid[j] <= !is_squashed(stg_rob[j], rollback);
        else         stg_valid[j] <= stg_valid[j-1] && !is_squashed(stg_rob[j-1], rollback);
      end
    end
  end

  // low 32 bits of the product, formed at stage 0 and carried down
  always_ff @(posedge clock) begin
    if (!hold[0]) begin
      stg_tag[0]  <= issue.tag;
      stg_rob[0]  <= issue.rob_idx;
      stg_prod[0] <= issue.src_a * issue.src_b;
    end
    for (int j = 1; j < MULT_STAGES; j++) begin
      if (!hold[j]) begin
        stg_tag[j]  <= stg_tag[j-1];
        stg_rob[j]  <= stg_rob[j-1];
        stg_prod[j] <= stg_prod[j-1];
      end
    end
  end

  assign result = '{valid:   stg_valid[LAST],
                    tag:     stg_tag[LAST],
                    value:   stg_prod[LAST],
                    rob_idx: stg_rob[LAST]};

endmodule

// File: hw/cdb_arbiter.sv
`timescale 1ns/1ps

module cdb_arbiter import cdb_pkg::*; (
  input  logic                         clock,
  input  logic                         reset,
  input  fu_result_t [NUM_FU-1:0]      fu_results,
  input  rollback_t                    rollback,
  output logic       [NUM_FU-1:0]      entry_free,
  output cdb_bcast_t                   cdb
);

  localparam int SEL_W = (NUM_FU > 1) ? $clog2(NUM_FU) : 1;

  // one holding entry per unit
  logic [NUM_FU-1:0] ent_valid;
  preg_tag_t         ent_tag   [NUM_FU];
  word_t             ent_value [NUM_FU];
  rob_idx_t          ent_rob   [NUM_FU];

  logic [SEL_W-1:0]  sel;
  logic              bcast_en;
  logic [NUM_FU-1:0] taken;

  // fixed priority, lowest unit number wins
  always_comb begin
    sel = '0;
    for (int i = NUM_FU - 1; i >= 0; i--) begin
      if (ent_valid[i]) sel = SEL_W'(i);
    end
  end

  // nothing goes out in a rollback cycle
  assign bcast_en = (|ent_valid) && !rollback.valid;

  always_comb begin
    for (int i = 0; i < NUM_FU; i++) begin
      taken[i]      = bcast_en && (sel == SEL_W'(i));
      // empty, or vacated by this cycle's broadcast
      entry_free[i] = !ent_valid[i] || taken[i];
    end
  end

  always_comb begin
    cdb.valid   = bcast_en;
    cdb.tag     = ent_tag[sel];
    cdb.value   = ent_value[sel];
    cdb.rob_idx = ent_rob[sel];
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      ent_valid <= '0;
    end else begin
      for (int i = 0; i < NUM_FU; i++) begin
        if (entry_free[i]) begin
          // refill from the unit, dropping an offer that is already dead
          ent_valid[i] <= fu_results[i].valid
                          && !is_squashed(fu_results[i].rob_idx, rollback);
        end else if (is_squashed(ent_rob[i], rollback)) begin
          ent_valid[i] <= 1'b0;
        end
      end
    end
  end

  // payload only written on a latch
  always_ff @(posedge clock) begin
    for (int i = 0; i < NUM_FU; i++) begin
      if (entry_free[i] && fu_results[i].valid) begin
        ent_tag[i]   <= fu_results[i].tag;
        ent_value[i] <= fu_results[i].value;
        ent_rob[i]   <= fu_results[i].rob_idx;
      end
    end
  end

endmodule

// File: hw/phys_regfile.sv
`timescale 1ns/1ps

module phys_regfile import cdb_pkg::*; #(
  parameter int NUM_PREG = cdb_pkg::NUM_PREG
) (
  input  logic       clock,
  input  logic       reset,
  input  cdb_bcast_t cdb,
  input  logic       alloc_valid,
  input  preg_tag_t  alloc_tag,
  input  preg_tag_t  read_tag,
  output word_t      read_value,
  output logic       read_ready
);

  word_t               values [NUM_PREG];
  logic [NUM_PREG-1:0] ready;

  // values come out of reset as zero
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < NUM_PREG; i++) begin
        values[i] <= '0;
      end
    end else if (cdb.valid) begin
      values[cdb.tag] <= cdb.value;
    end
  end

  // ready bits
  // broadcast is written last so it wins over an allocation of the same tag
  always_ff @(posedge clock) begin
    if (reset) begin
      ready <= '1;
    end else begin
      if (alloc_valid) begin
        ready[alloc_tag] <= 1'b0;
      end
      if (cdb.valid) begin
        ready[cdb.tag] <= 1'b1;
      end
    end
  end

  // async read, no bypass of this cycle's broadcast
  assign read_value = values[read_tag];
  assign read_ready = ready[read_tag];

endmodule

// File: hw/complete_stage.sv
`timescale 1ns/1ps

module complete_stage import cdb_pkg::*; #(
  parameter int MULT_STAGES = 3
) (
  input  logic       clock,
  input  logic       reset,
  input  issue_op_t  alu_issue,
  input  issue_op_t  mult_issue,
  input  rollback_t  rollback,
  input  logic       alloc_valid,
  input  preg_tag_t  alloc_tag,
  input  preg_tag_t  read_tag,
  output logic       alu_ready,
  output logic       mult_ready,
  output cdb_bcast_t cdb,
  output word_t      read_value,
  output logic       read_ready
);

  // unit offers and arbiter free bits, indexed by unit number
  fu_result_t [NUM_FU-1:0] fu_results;
  logic       [NUM_FU-1:0] entry_free;

  alu_unit u_alu (
    .clock       (clock),
    .reset       (reset),
    .issue       (alu_issue),
    .rollback    (rollback),
    .entry_free  (entry_free[FU_ALU]),
    .result      (fu_results[FU_ALU]),
    .issue_ready (alu_ready)
  );

  mult_unit #(
    .MULT_STAGES (MULT_STAGES)
  ) u_mult (
    .clock       (clock),
    .reset       (reset),
    .issue       (mult_issue),
    .rollback    (rollback),
    .entry_free  (entry_free[FU_MULT]),
    .result      (fu_results[FU_MULT]),
    .issue_ready (mult_ready)
  );

  cdb_arbiter u_arbiter (
    .clock      (clock),
    .reset      (reset),
    .fu_results (fu_results),
    .rollback   (rollback),
    .entry_free (entry_free),
    .cdb        (cdb)
  );

  // bus broadcast also leaves the top for rob and reservation stations
  phys_regfile #(
    .NUM_PREG (NUM_PREG)
  ) u_regfile (
    .clock       (clock),
    .reset       (reset),
    .cdb         (cdb),
    .alloc_valid (alloc_valid),
    .alloc_tag   (alloc_tag),
    .read_tag    (read_tag),
    .read_value  (read_value),
    .read_ready  (read_ready)
  );

endmodule

// File: bench/complete_props.sv
`timescale 1ns/1ps

module cdb_props import cdb_pkg::*; (
  input logic                        clock,
  input logic                        reset,
  input rollback_t                   rollback,
  input logic [NUM_FU-1:0]           entry_free,
  input cdb_bcast_t                  cdb,
  input logic [NUM_FU-1:0]           ent_valid,
  input logic [$clog2(NUM_FU)-1:0]   sel
);

  // bus stays quiet while a rollback is applied
  no_bcast_on_rollback: assert property (@(posedge clock) disable iff (reset)
    rollback.valid |-> !cdb.valid)
    else $error("broadcast seen in a rollback cycle");

  // selected entry holds a result and no lower unit is waiting
  bcast_from_occupied: assert property (@(posedge clock) disable iff (reset)
    cdb.valid |-> ent_valid[sel]
                  && ((ent_valid & ((NUM_FU'(1) << sel) - NUM_FU'(1))) == '0))
    else $error("broadcast from an empty entry or out of priority order");

  // all entries empty right after reset
  free_after_reset: assert property (@(posedge clock)
    $fell(reset) |-> &entry_free)
    else $error("entry not free after reset");

endmodule

bind cdb_arbiter cdb_props u_props (
  .clock      (clock),
  .reset      (reset),
  .rollback   (rollback),
  .entry_free (entry_free),
  .cdb        (cdb),
  .ent_valid  (ent_valid),
  .sel        (sel)
);

// File: bench/complete_tb.sv
`timescale 1ns/1ps

module complete_tb import cdb_pkg::*; ();

  localparam int MULT_STAGES = 3;
  localparam int CYCLE_LIMIT = 2000;

  logic       clock;
  logic       reset;
  issue_op_t  alu_issue;
  issue_op_t  mult_issue;
  rollback_t  rollback;
  logic       alloc_valid;
  preg_tag_t  alloc_tag;
  preg_tag_t  read_tag;
  logic       alu_ready;
  logic       mult_ready;
  cdb_bcast_t cdb;
  word_t      read_value;
  logic       read_ready;

  logic [31:0] rng_state;
  int          cycles;
  // every broadcast, in bus order
  cdb_bcast_t  log_q[$];

  complete_stage #(
    .MULT_STAGES (MULT_STAGES)
  ) dut (
    .clock       (clock),
    .reset       (reset),
    .alu_issue   (alu_issue),
    .mult_issue  (mult_issue),
    .rollback    (rollback),
    .alloc_valid (alloc_valid),
    .alloc_tag   (alloc_tag),
    .read_tag    (read_tag),
    .alu_ready   (alu_ready),
    .mult_ready  (mult_ready),
    .cdb         (cdb),
    .read_value  (read_value),
    .read_ready  (read_ready)
  );

  always #10 clock = !clock;

  // bus monitor, sampled on the rising edge
  always @(posedge clock) begin
    if (!reset && cdb.valid) begin
      log_q.push_back(cdb);
    end
  end

  // run limit
  always @(posedge clock) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, the tests did not finish", cycles);
      $display(">>> FAIL");
      $fatal(1);
    end
  end

  function automatic logic [31:0] xorshift();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // reference results
  function automatic word_t alu_model(alu_op_t op, word_t a, word_t b);
    case (op)
      ALU_ADD: return a + b;
      ALU_SUB: return a - b;
      ALU_AND: return a & b;
      default: return a ^ b;
    endcase
  endfunction

  // younger than the rollback point and not past the tail
  function automatic logic younger(int idx, int rb_idx, int tail);
    int d_entry;
    int d_tail;
    d_entry = (idx - rb_idx + NUM_ROB) % NUM_ROB;
    d_tail  = (tail - rb_idx + NUM_ROB) % NUM_ROB;
    return (d_entry > 0) && (d_entry <= d_tail);
  endfunction

  function automatic issue_op_t make_op(alu_op_t op, word_t a, word_t b, preg_tag_t tag,
                                        rob_idx_t rob);
    issue_op_t o;
    o.valid   = 1'b1;
    o.op      = op;
    o.src_a   = a;
    o.src_b   = b;
    o.tag     = tag;
    o.rob_idx = rob;
    return o;
  endfunction

  task automatic fail_value(string name, logic [31:0] got, logic [31:0] exp);
    $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
    $display(">>> FAIL");
    $fatal(1);
  endtask

  task automatic check_word(string name, word_t got, word_t exp);
    if (got !== exp) fail_value(name, got, exp);
  endtask

  task automatic check_tag(string name, preg_tag_t got, preg_tag_t exp);
    if (got !== exp) fail_value(name, got, exp);
  endtask

  task automatic check_rob(string name, rob_idx_t got, rob_idx_t exp);
    if (got !== exp) fail_value(name, got, exp);
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) fail_value(name, got, exp);
  endtask

  // step to the next falling edge and drop all strobes
  task automatic next_cycle();
    @(negedge clock);
    alu_issue.valid  = 1'b0;
    mult_issue.valid = 1'b0;
    rollback.valid   = 1'b0;
    alloc_valid      = 1'b0;
  endtask

  task automatic wait_for_tag(preg_tag_t tag, output int idx);
    idx = -1;
    while (idx < 0) begin
      foreach (log_q[i]) begin
        if (log_q[i].tag == tag) idx = i;
      end
      if (idx < 0) @(negedge clock);
    end
  endtask

  task automatic wait_count(int n);
    while (log_q.size() < n) @(negedge clock);
  endtask

  task automatic read_check(preg_tag_t tag, word_t exp_val, logic exp_rdy);
    read_tag = tag;
    #1;
    check_bit("read_ready", read_ready, exp_rdy);
    if (exp_rdy) check_word("read_value", read_value, exp_val);
  endtask

  task automatic test_alu_ops();
    word_t a;
    word_t b;
    word_t exp;
    int    idx;
    for (int k = 0; k < 4; k++) begin
      log_q.delete();
      a   = xorshift();
      b   = xorshift();
      exp = alu_model(alu_op_t'(k), a, b);
      alu_issue = make_op(alu_op_t'(k), a, b, preg_tag_t'(k + 1), rob_idx_t'(k));
      next_cycle();
      wait_for_tag(preg_tag_t'(k + 1), idx);
      check_word("cdb.value", log_q[idx].value, exp);
      check_rob("cdb.rob_idx", log_q[idx].rob_idx, rob_idx_t'(k));
      read_check(preg_tag_t'(k + 1), exp, 1'b1);
    end
  endtask

  task automatic test_mult_pipe();
    word_t a [MULT_STAGES];
    word_t b [MULT_STAGES];
    log_q.delete();
    for (int k = 0; k < MULT_STAGES; k++) begin
      a[k] = xorshift();
      b[k] = xorshift();
      mult_issue = make_op(ALU_ADD, a[k], b[k], preg_tag_t'(10 + k), rob_idx_t'(10 + k));
      next_cycle();
    end
    wait_count(MULT_STAGES);
    for (int k = 0; k < MULT_STAGES; k++) begin
      check_tag("cdb.tag", log_q[k].tag, preg_tag_t'(10 + k));
      check_word("cdb.value", log_q[k].value, a[k] * b[k]);
    end
  endtask

  task automatic test_contention();
    word_t a;
    word_t b;
    word_t c;
    word_t d;
    log_q.delete();
    a = xorshift();
    b = xorshift();
    c = xorshift();
    d = xorshift();
    mult_issue = make_op(ALU_ADD, a, b, 6'd31, 5'd3);
    next_cycle();
    // mult takes two edges more than the alu to reach its entry
    repeat (MULT_STAGES - 2) next_cycle();
    alu_issue = make_op(ALU_XOR, c, d, 6'd30, 5'd4);
    next_cycle();
    wait_count(2);
    check_tag("cdb.tag first", log_q[0].tag, 6'd30);
    check_word("cdb.value first", log_q[0].value, c ^ d);
    check_tag("cdb.tag second", log_q[1].tag, 6'd31);
    check_word("cdb.value second", log_q[1].value, a * b);
  endtask

  task automatic test_backpressure();
    int        alu_sent;
    int        mult_sent;
    int        step;
    int        hits [NUM_PREG];
    word_t     exp_val [NUM_PREG];
    logic      saw_stall;
    word_t     a;
    word_t     b;
    preg_tag_t t;
    log_q.delete();
    alu_sent  = 0;
    mult_sent = 0;
    step      = 0;
    saw_stall = 1'b0;
    foreach (hits[i]) hits[i] = 0;
    while (mult_sent < 6) begin
      if (!mult_ready) saw_stall = 1'b1;
      if (step < 10 && alu_ready) begin
        a = xorshift();
        b = xorshift();
        t = preg_tag_t'(20 + alu_sent);
        exp_val[t] = a + b;
        alu_issue = make_op(ALU_ADD, a, b, t, t[4:0]);
        alu_sent++;
      end
      if (mult_ready) begin
        a = xorshift();
        b = xorshift();
        t = preg_tag_t'(40 + mult_sent);
        exp_val[t] = a * b;
        mult_issue = make_op(ALU_ADD, a, b, t, t[4:0]);
        mult_sent++;
      end
      step++;
      next_cycle();
    end
    wait_count(alu_sent + mult_sent);
    repeat (10) next_cycle();
    check_bit("mult_ready stall seen", saw_stall, 1'b1);
    check_bit("broadcast count", log_q.size() == alu_sent + mult_sent, 1'b1);
    foreach (log_q[i]) begin
      t = log_q[i].tag;
      hits[t]++;
      check_word("cdb.value", log_q[i].value, exp_val[t]);
    end
    for (int k = 0; k < mult_sent; k++) begin
      check_bit("mult broadcast once", hits[40 + k] == 1, 1'b1);
    end
  endtask

  // three multiplies and one alu op in flight, then a rollback
  // extra delay lets results settle into the arbiter entries first
  task automatic rollback_case(int rb_idx, int tail, int r0, int r1, int r2, int r3,
                               int base, int delay);
    int   robs [4];
    int   seen;
    logic gone;
    robs = '{r0, r1, r2, r3};
    log_q.delete();
    for (int k = 0; k < 3; k++) begin
      mult_issue = make_op(ALU_ADD, xorshift(), xorshift(), preg_tag_t'(base + k),
                           rob_idx_t'(robs[k]));
      if (k == 2) begin
        alu_issue = make_op(ALU_ADD, xorshift(), xorshift(), preg_tag_t'(base + 3),
                            rob_idx_t'(robs[3]));
      end
      next_cycle();
    end
    repeat (delay) next_cycle();
    rollback.valid        = 1'b1;
    rollback.rollback_idx = rob_idx_t'(rb_idx);
    rollback.tail_idx     = rob_idx_t'(tail);
    next_cycle();
    repeat (12) next_cycle();
    for (int k = 0; k < 4; k++) begin
      seen = 0;
      foreach (log_q[i]) begin
        if (log_q[i].tag == preg_tag_t'(base + k)) seen++;
      end
      gone = younger(robs[k], rb_idx, tail);
      check_bit("broadcast after rollback", seen == 1, !gone);
      check_bit("no duplicate broadcast", seen > 1, 1'b0);
    end
  endtask

  task automatic test_rollback();
    rollback_case(5, 9, 4, 5, 7, 8, 50, 0);
    // tail behind the rollback point, entries held in the arbiter
    rollback_case(30, 2, 29, 30, 31, 1, 54, 1);
  endtask

  task automatic test_alloc();
    word_t a;
    word_t b;
    int    idx;
    log_q.delete();
    alloc_valid = 1'b1;
    alloc_tag   = 6'd60;
    next_cycle();
    read_check(6'd60, '0, 1'b0);
    a = xorshift();
    b = xorshift();
    alu_issue = make_op(ALU_SUB, a, b, 6'd60, 5'd12);
    next_cycle();
    wait_for_tag(6'd60, idx);
    check_word("cdb.value", log_q[idx].value, a - b);
    read_check(6'd60, a - b, 1'b1);
  endtask

  initial begin
    clock       = 1'b0;
    reset       = 1'b1;
    alu_issue   = '0;
    mult_issue  = '0;
    rollback    = '0;
    alloc_valid = 1'b0;
    alloc_tag   = '0;
    read_tag    = '0;
    rng_state   = 32'h8ac0;
    cycles      = 0;
    repeat (16) @(negedge clock);
    reset = 1'b0;
    next_cycle();
    check_bit("alu_ready", alu_ready, 1'b1);
    check_bit("mult_ready", mult_ready, 1'b1);
    check_bit("cdb.valid", cdb.valid, 1'b0);
    test_alu_ops();
    test_mult_pipe();
    test_contention();
    test_backpressure();
    test_rollback();
    test_alloc();
    $display(">>> PASS");
    $finish;
  end

endmodule

// File: complete_stage.f
hw/cdb_pkg.sv
hw/alu_unit.sv
hw/mult_unit.sv
hw/cdb_arbiter.sv
hw/phys_regfile.sv
hw/complete_stage.sv
bench/complete_props.sv
bench/complete_tb.sv

// File: Makefile
# Verilator build for the completion stage testbench

VERILATOR ?= verilator
TOP       ?= complete_tb
FILELIST  ?= complete_stage.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides pass or fail
run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q '^>>> PASS$$' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
